//--- bench/icache_mem_model.sv
`timescale 1ns/10ps

// Bus slave for line fills
// Word at byte address A reads as A ^ pattern
// One address region answers with err, another with exv
module icache_mem_model #(
	parameter logic [31:0] pattern    = 32'h0,
	parameter logic [15:0] err_region = 16'h0001,
	parameter logic [15:0] exv_region = 16'h0002,
	parameter logic [31:0] seed_init  = 32'h1
) (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic [31:0] adr_i,
	input  logic        burst_ok_i,
	output logic        bok_o,
	output logic        ack_o,
	output logic        err_o,
	output logic        exv_o,
	output logic [31:0] dat_o
);

	integer     seed = seed_init;
	logic [1:0] wait_q;

	// Burst permission comes straight from the bench
	assign bok_o = burst_ok_i;

	always @(posedge clk) begin
		if (rst_i) begin
			ack_o  <= 1'b0;
			err_o  <= 1'b0;
			exv_o  <= 1'b0;
			dat_o  <= 32'h0;
			wait_q <= 2'd0;
		end else if (ack_o || err_o || exv_o) begin
			// Response taken this cycle
			ack_o  <= 1'b0;
			err_o  <= 1'b0;
			exv_o  <= 1'b0;
			// Next beat waits 0 to 2 cycles
			wait_q <= 2'({$random(seed)} % 3);
		end else if (cyc_i && stb_i) begin
			if (wait_q != 2'd0) begin
				wait_q <= wait_q - 2'd1;
			end else begin
				if (adr_i[31:16] == exv_region)
					exv_o <= 1'b1;
				else if (adr_i[31:16] == err_region)
					err_o <= 1'b1;
				else
					ack_o <= 1'b1;
				dat_o <= adr_i ^ pattern;
			end
		end
	end

endmodule

//--- bench/icache_tb.sv
`timescale 1ns/10ps

`include "icache_cfg.svh"

module icache_tb;

	localparam logic [31:0] data_pattern = 32'h5a3c_96e1;
	localparam logic [15:0] err_region   = 16'h0001;
	localparam logic [15:0] exv_region   = 16'h0002;
	localparam logic [31:0] rand_seed    = 32'h34097b01;
	// About 25 fetches of at most 30 cycles each, with a wide margin
	localparam int          cycle_limit  = 4000;

	logic               clk;
	logic               rst_i;
	logic               fetch_req_i;
	logic [31:0]        fetch_adr_i;
	logic               fetch_ready_o;
	logic [31:0]        fetch_word_o;
	icache_pkg::fault_e fetch_fault_o;
	logic               inv_i;
	logic [31:0]        inv_adr_i;
	logic [15:0]        fill_count_o;
	logic               cyc_o;
	logic               stb_o;
	logic [2:0]         cti_o;
	logic [31:0]        adr_o;
	logic               bok_i;
	logic               ack_i;
	logic               err_i;
	logic               exv_i;
	logic [31:0]        dat_i;

	// Bench state seen by the assertions
	logic               burst_ok;
	logic               fetch_is_hit;
	logic [15:0]        fills_exp;
	logic               ready_q;
	logic [2:0]         beat_cnt;
	logic               prev_cyc;
	logic [31:0]        prev_adr;
	int                 cycle_cnt = 0;

	icache_top icache_top_i (
		.clk(clk), .rst_i(rst_i),
		.fetch_req_i(fetch_req_i), .fetch_adr_i(fetch_adr_i),
		.fetch_ready_o(fetch_ready_o), .fetch_word_o(fetch_word_o),
		.fetch_fault_o(fetch_fault_o),
		.inv_i(inv_i), .inv_adr_i(inv_adr_i), .fill_count_o(fill_count_o),
		.cyc_o(cyc_o), .stb_o(stb_o), .cti_o(cti_o), .adr_o(adr_o),
		.bok_i(bok_i), .ack_i(ack_i), .err_i(err_i), .exv_i(exv_i), .dat_i(dat_i)
	);

	icache_mem_model #(
		.pattern(data_pattern), .err_region(err_region),
		.exv_region(exv_region), .seed_init(rand_seed)
	) mem_model_i (
		.clk(clk), .rst_i(rst_i), .cyc_i(cyc_o), .stb_i(stb_o), .adr_i(adr_o),
		.burst_ok_i(burst_ok), .bok_o(bok_i),
		.ack_o(ack_i), .err_o(err_i), .exv_o(exv_i), .dat_o(dat_i)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ========================================
	// Helpers
	// ========================================

	// Memory data rule on the word-aligned address
	function automatic logic [31:0] expected_word(input logic [31:0] adr);
		return {adr[31:2], 2'b00} ^ data_pattern;
	endfunction

	function automatic logic in_region(input logic [31:0] adr, input logic [15:0] region);
		return adr[31:16] == region;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("ERROR %s: expected %0h, actual %0h", name, exp, act);
		$display("TB FAILED");
		$fatal(1, "check %s did not hold", name);
	endtask

	// Present one fetch and hold it until the cache answers
	task automatic fetch(input logic [31:0] adr, input logic hit);
		@(negedge clk);
		fetch_adr_i  = adr;
		fetch_req_i  = 1'b1;
		fetch_is_hit = hit;
		if (!hit)
			fills_exp = fills_exp + 16'd1;
		do @(negedge clk); while (!ready_q);
		fetch_req_i  = 1'b0;
		fetch_is_hit = 1'b0;
	endtask

	// Pulse invalidate, then leave idle time for it to be served
	task automatic invalidate(input logic [31:0] adr);
		@(negedge clk);
		inv_i     = 1'b1;
		inv_adr_i = adr;
		@(negedge clk);
		inv_i = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	// ========================================
	// Bus and fetch tracking
	// ========================================

	always @(posedge clk) begin
		ready_q  <= fetch_ready_o;
		prev_cyc <= cyc_o;
		prev_adr <= adr_o;
		// Completed beats inside the current cycle
		if (rst_i || !cyc_o)
			beat_cnt <= 3'd0;
		else if (stb_o && (ack_i || err_i || exv_i))
			beat_cnt <= beat_cnt + 3'd1;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == cycle_limit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	// ========================================
	// Checks
	// ========================================

	a_reset_idle: assert property (@(posedge clk) $fell(rst_i) |->
		!(cyc_o || stb_o || fetch_ready_o))
		else report_mismatch("reset_idle", 32'd0,
			32'($sampled({cyc_o, stb_o, fetch_ready_o})));
	a_reset_count: assert property (@(posedge clk) $fell(rst_i) |-> fill_count_o == 16'd0)
		else report_mismatch("reset_count", 32'd0, 32'($sampled(fill_count_o)));

	// Clean fetches follow the data rule, misses and hits alike
	a_fetch_data: assert property (@(posedge clk) disable iff (rst_i)
		(fetch_ready_o && fetch_fault_o == icache_pkg::fault_none) |->
		fetch_word_o == expected_word(fetch_adr_i))
		else report_mismatch("fetch_data", expected_word($sampled(fetch_adr_i)),
			$sampled(fetch_word_o));
	a_clean_code: assert property (@(posedge clk) disable iff (rst_i)
		(fetch_ready_o && !in_region(fetch_adr_i, err_region) &&
		!in_region(fetch_adr_i, exv_region)) |-> fetch_fault_o == icache_pkg::fault_none)
		else report_mismatch("clean_code", 32'(icache_pkg::fault_none),
			32'($sampled(fetch_fault_o)));

	// Faulted lines
	a_err_word: assert property (@(posedge clk) disable iff (rst_i)
		(fetch_ready_o && in_region(fetch_adr_i, err_region)) |->
		fetch_word_o == `ICACHE_NOP)
		else report_mismatch("err_word", `ICACHE_NOP, $sampled(fetch_word_o));
	a_err_code: assert property (@(posedge clk) disable iff (rst_i)
		(fetch_ready_o && in_region(fetch_adr_i, err_region)) |->
		fetch_fault_o == icache_pkg::fault_bus_err)
		else report_mismatch("err_code", 32'(icache_pkg::fault_bus_err),
			32'($sampled(fetch_fault_o)));
	a_exv_word: assert property (@(posedge clk) disable iff (rst_i)
		(fetch_ready_o && in_region(fetch_adr_i, exv_region)) |->
		fetch_word_o == `ICACHE_NOP)
		else report_mismatch("exv_word", `ICACHE_NOP, $sampled(fetch_word_o));
	a_exv_code: assert property (@(posedge clk) disable iff (rst_i)
		(fetch_ready_o && in_region(fetch_adr_i, exv_region)) |->
		fetch_fault_o == icache_pkg::fault_exv)
		else report_mismatch("exv_code", 32'(icache_pkg::fault_exv),
			32'($sampled(fetch_fault_o)));

	// Repeat fetch answers at once, so no bus cycle runs
	a_repeat_hit: assert property (@(posedge clk) disable iff (rst_i)
		(fetch_req_i && fetch_is_hit) |-> fetch_ready_o)
		else report_mismatch("repeat_hit", 32'd1, 32'($sampled(fetch_ready_o)));
	// One count per expected miss, none for hits
	a_fill_count: assert property (@(posedge clk) disable iff (rst_i)
		fetch_ready_o |-> fill_count_o == fills_exp)
		else report_mismatch("fill_count", 32'($sampled(fills_exp)),
			32'($sampled(fill_count_o)));

	// Line-aligned start, 4 bytes per completed beat
	a_line_start: assert property (@(posedge clk) disable iff (rst_i)
		$rose(cyc_o) |-> adr_o[3:0] == 4'h0)
		else report_mismatch("line_start", 32'd0, 32'($sampled(adr_o[3:0])));
	a_beat_adr: assert property (@(posedge clk) disable iff (rst_i)
		stb_o |-> adr_o[3:0] == {beat_cnt[1:0], 2'b00})
		else report_mismatch("beat_adr", 32'({$sampled(beat_cnt[1:0]), 2'b00}),
			32'($sampled(adr_o[3:0])));
	a_line_hold: assert property (@(posedge clk) disable iff (rst_i)
		(cyc_o && prev_cyc) |-> adr_o[31:4] == prev_adr[31:4])
		else report_mismatch("line_hold", 32'($sampled(prev_adr[31:4])),
			32'($sampled(adr_o[31:4])));

	// Burst cycle types
	a_burst_incr: assert property (@(posedge clk) disable iff (rst_i)
		(bok_i && stb_o && beat_cnt < 3'd3) |-> cti_o == icache_pkg::cti_incr)
		else report_mismatch("burst_incr", 32'(icache_pkg::cti_incr), 32'($sampled(cti_o)));
	a_burst_end: assert property (@(posedge clk) disable iff (rst_i)
		(bok_i && stb_o && ack_i && beat_cnt == 3'd3) |-> cti_o == icache_pkg::cti_end)
		else report_mismatch("burst_end", 32'(icache_pkg::cti_end), 32'($sampled(cti_o)));
	a_end_last: assert property (@(posedge clk) disable iff (rst_i)
		(stb_o && cti_o == icache_pkg::cti_end) |-> beat_cnt == 3'd3)
		else report_mismatch("end_last", 32'd3, 32'($sampled(beat_cnt)));

	// Single transfers when burst is refused
	a_single_cti: assert property (@(posedge clk) disable iff (rst_i)
		(!bok_i && cyc_o) |-> cti_o == icache_pkg::cti_classic)
		else report_mismatch("single_cti", 32'(icache_pkg::cti_classic),
			32'($sampled(cti_o)));
	a_single_gap: assert property (@(posedge clk) disable iff (rst_i)
		(!bok_i && stb_o && ack_i && beat_cnt < 3'd3) |=> !stb_o)
		else report_mismatch("single_gap", 32'd0, 32'($sampled(stb_o)));

	// ========================================
	// Stimulus
	// ========================================

	initial begin
		rst_i        = 1'b1;
		fetch_req_i  = 1'b0;
		fetch_adr_i  = 32'h0;
		inv_i        = 1'b0;
		inv_adr_i    = 32'h0;
		burst_ok     = 1'b1;
		fetch_is_hit = 1'b0;
		fills_exp    = 16'd0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		// Burst fills, then hits in the same lines
		fetch(32'h0000_0104, 1'b0);
		fetch(32'h0000_0100, 1'b1);
		fetch(32'h0000_010c, 1'b1);
		fetch(32'h0000_2230, 1'b0);
		fetch(32'h0000_2234, 1'b1);

		// Fault regions, repeats served from the stored line
		fetch(32'h0001_0040, 1'b0);
		fetch(32'h0001_0044, 1'b1);
		fetch(32'h0002_0088, 1'b0);
		fetch(32'h0002_008c, 1'b1);

		// Invalidate forces a refill
		fetch(32'h0000_0100, 1'b1);
		invalidate(32'h0000_0100);
		fetch(32'h0000_0108, 1'b0);
		fetch(32'h0000_0100, 1'b1);

		// Burst refused by the slave
		@(negedge clk);
		burst_ok = 1'b0;
		fetch(32'h0000_3300, 1'b0);
		fetch(32'h0000_330c, 1'b1);
		fetch(32'h0000_4404, 1'b0);
		fetch(32'h0000_4400, 1'b1);
		fetch(32'h0000_2230, 1'b1);

		// Conflict on index 0, and an invalidate with a stale tag
		@(negedge clk);
		burst_ok = 1'b1;
		fetch(32'h0000_1100, 1'b0);
		fetch(32'h0000_0104, 1'b0);
		invalidate(32'h0000_1100);
		fetch(32'h0000_0104, 1'b1);

		repeat (4) @(negedge clk);
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert --top-module icache_tb -f src.f -o icache_sim

out=$(./obj_dir/icache_sim 2>&1 || true)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "TB PASSED"

//--- src.f
+incdir+src
src/icache_pkg.sv
src/icache_fill_if.sv
src/icache_array.sv
src/icache_ctrl.sv
src/icache_bus_master.sv
src/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

//--- src/icache_array.sv
`timescale 1ns/10ps

`include "icache_cfg.svh"

module icache_array (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [`ICACHE_AW-1:0] lookup_adr_i,
	output logic                  hit_o,
	output logic [31:0]           word_o,
	output icache_pkg::fault_e    fault_o,
	input  logic                  wr_i,
	input  logic [`ICACHE_AW-1:0] wr_adr_i,
	input  icache_pkg::line_t     wr_line_i,
	input  logic                  inv_i,
	input  logic [`ICACHE_AW-1:0] inv_adr_i
);

	// Address split: tag | index | word | byte
	localparam int word_w  = $clog2(`ICACHE_BEATS);
	localparam int idx_w   = $clog2(`ICACHE_LINES);
	localparam int idx_lsb = 2 + word_w;
	localparam int tag_lsb = idx_lsb + idx_w;
	localparam int tag_w   = `ICACHE_AW - tag_lsb;

	// Index arithmetic only works for a power-of-two line count
	if ((1 << idx_w) != `ICACHE_LINES) begin : g_bad_lines
		$error("ICACHE_LINES must be a power of two");
	end

	// ========================================
	// Storage
	// ========================================

	logic [`ICACHE_LINES-1:0] valid_q;
	logic [tag_w-1:0]         tag_q [`ICACHE_LINES];
	icache_pkg::line_t        line_q [`ICACHE_LINES];

	// ========================================
	// Fetch lookup
	// ========================================

	logic [idx_w-1:0]  lk_idx;
	logic [word_w-1:0] lk_word;
	logic [tag_w-1:0]  lk_tag;
	icache_pkg::line_t lk_line;

	assign lk_idx  = lookup_adr_i[idx_lsb +: idx_w];
	assign lk_word = lookup_adr_i[2 +: word_w];
	assign lk_tag  = lookup_adr_i[`ICACHE_AW-1:tag_lsb];
	assign lk_line = line_q[lk_idx];

	// Hit needs a live line with the same tag
	assign hit_o   = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
	assign fault_o = lk_line.fault;

	// Faulted lines never hand out their data
	assign word_o = (lk_line.fault == icache_pkg::fault_none) ?
		lk_line.words[lk_word] : `ICACHE_NOP;

	// ========================================
	// Line write and invalidate
	// ========================================

	logic [idx_w-1:0] wr_idx;
	logic [idx_w-1:0] inv_idx;
	logic [tag_w-1:0] inv_tag;

	assign wr_idx  = wr_adr_i[idx_lsb +: idx_w];
	assign inv_idx = inv_adr_i[idx_lsb +: idx_w];
	assign inv_tag = inv_adr_i[`ICACHE_AW-1:tag_lsb];

	// Valid bits
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else begin
			if (wr_i)
				valid_q[wr_idx] <= 1'b1;
			// Only drop the line if it still holds that address
			if (inv_i && (tag_q[inv_idx] == inv_tag))
				valid_q[inv_idx] <= 1'b0;
		end
	end

	// Tag, fault and words
	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_q[wr_idx]  <= wr_adr_i[`ICACHE_AW-1:tag_lsb];
			line_q[wr_idx] <= wr_line_i;
		end
	end

	// Controller serializes fills and invalidates
	a_wr_inv_excl: assert property (@(posedge clk) disable iff (rst_i)
		!(wr_i && inv_i));

endmodule

//--- src/icache_bus_master.sv
`timescale 1ns/10ps

`include "icache_cfg.svh"

module icache_bus_master (
	input  logic                  clk,
	input  logic                  rst_i,
	icache_fill_if.master         fill,
	output logic                  cyc_o,
	output logic                  stb_o,
	output logic [2:0]            cti_o,
	output logic [`ICACHE_AW-1:0] adr_o,
	input  logic                  bok_i,
	input  logic                  ack_i,
	input  logic                  err_i,
	input  logic                  exv_i,
	input  logic [31:0]           dat_i
);

	localparam int beat_w = $clog2(`ICACHE_BEATS);
	localparam logic [beat_w-1:0] last_beat = beat_w'(`ICACHE_BEATS - 1);

	typedef enum logic [1:0] {
		m_idle,
		m_beat,
		m_gap,
		m_done
	} mstate_e;

	mstate_e               state_q;
	logic                  cyc_q;
	logic                  stb_q;
	logic [2:0]            cti_q;
	logic                  burst_q;
	logic [beat_w-1:0]     beat_q;
	logic [`ICACHE_AW-1:0] adr_q;
	icache_pkg::line_t     line_q;
	logic                  start;
	logic                  beat_end;
	logic                  fault;

	assign start    = (state_q == m_idle) && fill.req;
	// Any of ack, err, exv closes the beat
	assign beat_end = (state_q == m_beat) && stb_q && (ack_i || err_i || exv_i);
	assign fault    = err_i || exv_i;

	assign cyc_o = cyc_q;
	assign stb_o = stb_q;
	assign cti_o = cti_q;
	assign adr_o = adr_q;

	assign fill.done = (state_q == m_done);
	assign fill.line = line_q;

	// ========================================
	// Cycle control
	// ========================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= m_idle;
			cyc_q   <= 1'b0;
			stb_q   <= 1'b0;
			cti_q   <= icache_pkg::cti_classic;
			burst_q <= 1'b0;
			beat_q  <= '0;
		end else begin
			case (state_q)
			m_idle: begin
				if (start) begin
					cyc_q   <= 1'b1;
					stb_q   <= 1'b1;
					beat_q  <= '0;
					// Burst only if the slave currently allows it
					burst_q <= bok_i;
					cti_q   <= bok_i ? icache_pkg::cti_incr : icache_pkg::cti_classic;
					state_q <= m_beat;
				end
			end
			m_beat: begin
				if (beat_end) begin
					if (fault || (beat_q == last_beat)) begin
						// Fault or last beat ends the cycle
						cyc_q   <= 1'b0;
						stb_q   <= 1'b0;
						cti_q   <= icache_pkg::cti_classic;
						state_q <= m_done;
					end else begin
						beat_q <= beat_q + 1'b1;
						if (burst_q && bok_i) begin
							cti_q <= (beat_q + 1'b1 == last_beat) ?
								icache_pkg::cti_end : icache_pkg::cti_incr;
						end else begin
							// Burst refused, single beats with a gap
							burst_q <= 1'b0;
							cti_q   <= icache_pkg::cti_classic;
							stb_q   <= 1'b0;
							state_q <= m_gap;
						end
					end
				end
			end
			m_gap: begin
				// Wait for the slave to release ack
				if (!ack_i) begin
					stb_q   <= 1'b1;
					state_q <= m_beat;
				end
			end
			m_done: state_q <= m_idle;
			default: state_q <= m_idle;
			endcase
		end
	end

	// ========================================
	// Address and line assembly
	// ========================================

	always_ff @(posedge clk) begin
		if (start) begin
			adr_q        <= fill.line_adr;
			line_q.fault <= icache_pkg::fault_none;
		end else if (beat_end && !fault && (beat_q != last_beat)) begin
			adr_q <= adr_q + `ICACHE_AW'(4);
		end

		if (beat_end) begin
			if (exv_i) begin
				line_q.fault <= icache_pkg::fault_exv;
				line_q.words <= {`ICACHE_BEATS{`ICACHE_NOP}};
			end else if (err_i) begin
				line_q.fault <= icache_pkg::fault_bus_err;
				line_q.words <= {`ICACHE_BEATS{`ICACHE_NOP}};
			end else begin
				line_q.words[beat_q] <= dat_i;
			end
		end
	end

	// End-of-burst code marks the final beat only
	a_cti_end_last: assert property (@(posedge clk) disable iff (rst_i)
		(stb_o && (cti_o == icache_pkg::cti_end)) |-> (adr_o[2 +: beat_w] == last_beat));

endmodule

//--- src/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ========================================
// Cache geometry
// ========================================

// Number of cache lines, power of two only
`define ICACHE_LINES 16

// 32-bit beats per line
`define ICACHE_BEATS 4

// Byte address width of fetch port and bus
`define ICACHE_AW 32

// ========================================
// Timing and fill data
// ========================================

// Cycles after a line write before lookups resume
`define ICACHE_SETTLE 2

// Returned in place of code from a faulted line
// Encodes addi x0,x0,0
`define ICACHE_NOP 32'h0000_0013

`endif

//--- src/icache_ctrl.sv
`timescale 1ns/10ps

`include "icache_cfg.svh"

module icache_ctrl (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  fetch_req_i,
	input  logic [`ICACHE_AW-1:0] fetch_adr_i,
	input  logic                  inv_i,
	input  logic [`ICACHE_AW-1:0] inv_adr_i,
	input  logic                  hit_i,
	output logic                  fetch_ready_o,
	output logic                  arr_wr_o,
	output logic [`ICACHE_AW-1:0] arr_wr_adr_o,
	output icache_pkg::line_t     arr_wr_line_o,
	output logic                  arr_inv_o,
	output logic [`ICACHE_AW-1:0] arr_inv_adr_o,
	output logic [15:0]           fill_count_o,
	icache_fill_if.ctrl           fill
);

	// Byte offset bits inside one line
	localparam int line_off = 2 + $clog2(`ICACHE_BEATS);
	localparam int settle_w = $clog2(`ICACHE_SETTLE + 1);
	localparam logic [settle_w-1:0] settle_last = settle_w'(`ICACHE_SETTLE - 1);

	typedef enum logic [2:0] {
		st_idle,
		st_request,
		st_wait_fill,
		st_write,
		st_settle
	} state_e;

	state_e                state_q;
	logic                  inv_pend_q;
	logic [`ICACHE_AW-1:0] inv_adr_q;
	logic [`ICACHE_AW-1:0] line_adr_q;
	icache_pkg::line_t     line_q;
	logic [settle_w-1:0]   settle_cnt_q;
	logic [15:0]           fill_count_q;
	logic                  miss;

	// Miss only counts in idle once invalidates are drained
	assign miss = (state_q == st_idle) && !inv_pend_q && fetch_req_i && !hit_i;

	// ========================================
	// Outputs
	// ========================================

	// Hits answer in the same cycle, only while idle
	assign fetch_ready_o = fetch_req_i && hit_i && (state_q == st_idle);

	// Pending invalidate takes one idle cycle
	assign arr_inv_o     = (state_q == st_idle) && inv_pend_q;
	assign arr_inv_adr_o = inv_adr_q;

	assign arr_wr_o      = (state_q == st_write);
	assign arr_wr_adr_o  = line_adr_q;
	assign arr_wr_line_o = line_q;

	// req drops the cycle after done, when state moves to write
	assign fill.req      = (state_q == st_request) || (state_q == st_wait_fill);
	assign fill.line_adr = line_adr_q;

	assign fill_count_o = fill_count_q;

	// ========================================
	// Control FSM
	// ========================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q      <= st_idle;
			inv_pend_q   <= 1'b0;
			settle_cnt_q <= '0;
			fill_count_q <= '0;
		end else begin
			// Served invalidate clears, a fresh pulse re-arms
			if (arr_inv_o)
				inv_pend_q <= 1'b0;
			if (inv_i)
				inv_pend_q <= 1'b1;

			case (state_q)
			st_idle: begin
				if (miss)
					state_q <= st_request;
			end
			st_request: begin
				state_q <= st_wait_fill;
			end
			st_wait_fill: begin
				if (fill.done)
					state_q <= st_write;
			end
			st_write: begin
				fill_count_q <= fill_count_q + 16'd1;
				settle_cnt_q <= '0;
				state_q      <= st_settle;
			end
			st_settle: begin
				// Let the new line reach the lookup path
				if (settle_cnt_q == settle_last)
					state_q <= st_idle;
				else
					settle_cnt_q <= settle_cnt_q + 1'b1;
			end
			default: state_q <= st_idle;
			endcase
		end
	end

	// ========================================
	// Address and line capture
	// ========================================

	always_ff @(posedge clk) begin
		if (inv_i)
			inv_adr_q <= inv_adr_i;
		if (miss)
			line_adr_q <= {fetch_adr_i[`ICACHE_AW-1:line_off], {line_off{1'b0}}};
		if ((state_q == st_wait_fill) && fill.done)
			line_q <= fill.line;
	end

	// Master may only finish a fill whose request is still held
	a_req_stable: assert property (@(posedge clk) disable iff (rst_i)
		fill.done |-> (state_q == st_wait_fill));

endmodule

//--- src/icache_fill_if.sv
`timescale 1ns/10ps

`include "icache_cfg.svh"

// Line-fill handshake between the cache controller and the bus master
// req rises with line_adr and holds until done
// done pulses for one cycle with line valid alongside
interface icache_fill_if;

	// ========================================
	// Request side
	// ========================================

	// Fill request, held stable until done
	logic req;
	// Byte address of the line, line aligned
	logic [`ICACHE_AW-1:0] line_adr;

	// ========================================
	// Response side
	// ========================================

	// Single-cycle completion pulse
	logic done;
	// Assembled words plus fault code
	icache_pkg::line_t line;

	// Controller view
	modport ctrl (
		output req,
		output line_adr,
		input  done,
		input  line
	);

	// Bus master view
	modport master (
		input  req,
		input  line_adr,
		output done,
		output line
	);

endinterface

//--- src/icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

	// ========================================
	// Fault codes
	// ========================================

	// Fault stored with a line and returned on every hit to it
	typedef enum logic [1:0] {
		fault_none    = 2'd0,
		fault_bus_err = 2'd1,
		fault_exv     = 2'd2
	} fault_e;

	// ========================================
	// Cache line
	// ========================================

	// One full line as filled from the bus
	// Word 0 sits at the line-aligned address
	typedef struct packed {
		fault_e                         fault;
		logic [`ICACHE_BEATS-1:0][31:0] words;
	} line_t;

	// ========================================
	// Bus cycle-type codes
	// ========================================

	// Single transfer
	localparam logic [2:0] cti_classic = 3'b000;
	// Incrementing burst, more beats follow
	localparam logic [2:0] cti_incr = 3'b010;
	// Final beat of a burst
	localparam logic [2:0] cti_end = 3'b111;

endpackage

//--- src/icache_top.sv
`timescale 1ns/10ps

`include "icache_cfg.svh"

module icache_top (
	input  logic                  clk,
	input  logic                  rst_i,
	// Fetch port
	input  logic                  fetch_req_i,
	input  logic [`ICACHE_AW-1:0] fetch_adr_i,
	output logic                  fetch_ready_o,
	output logic [31:0]           fetch_word_o,
	output icache_pkg::fault_e    fetch_fault_o,
	// Line invalidate
	input  logic                  inv_i,
	input  logic [`ICACHE_AW-1:0] inv_adr_i,
	output logic [15:0]           fill_count_o,
	// Burst bus
	output logic                  cyc_o,
	output logic                  stb_o,
	output logic [2:0]            cti_o,
	output logic [`ICACHE_AW-1:0] adr_o,
	input  logic                  bok_i,
	input  logic                  ack_i,
	input  logic                  err_i,
	input  logic                  exv_i,
	input  logic [31:0]           dat_i
);

	// Controller to array
	logic                  hit;
	logic                  arr_wr;
	logic [`ICACHE_AW-1:0] arr_wr_adr;
	icache_pkg::line_t     arr_wr_line;
	logic                  arr_inv;
	logic [`ICACHE_AW-1:0] arr_inv_adr;

	icache_fill_if fill_if ();

	icache_array icache_array_i (
		.clk(clk), .rst_i(rst_i),
		.lookup_adr_i(fetch_adr_i), .hit_o(hit),
		.word_o(fetch_word_o), .fault_o(fetch_fault_o),
		.wr_i(arr_wr), .wr_adr_i(arr_wr_adr), .wr_line_i(arr_wr_line),
		.inv_i(arr_inv), .inv_adr_i(arr_inv_adr)
	);

	icache_ctrl icache_ctrl_i (
		.clk(clk), .rst_i(rst_i),
		.fetch_req_i(fetch_req_i), .fetch_adr_i(fetch_adr_i),
		.inv_i(inv_i), .inv_adr_i(inv_adr_i), .hit_i(hit),
		.fetch_ready_o(fetch_ready_o),
		.arr_wr_o(arr_wr), .arr_wr_adr_o(arr_wr_adr), .arr_wr_line_o(arr_wr_line),
		.arr_inv_o(arr_inv), .arr_inv_adr_o(arr_inv_adr),
		.fill_count_o(fill_count_o), .fill(fill_if.ctrl)
	);

	icache_bus_master icache_bus_master_i (
		.clk(clk), .rst_i(rst_i), .fill(fill_if.master),
		.cyc_o(cyc_o), .stb_o(stb_o), .cti_o(cti_o), .adr_o(adr_o),
		.bok_i(bok_i), .ack_i(ack_i), .err_i(err_i), .exv_i(exv_i), .dat_i(dat_i)
	);

endmodule
